// ==== fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// ==============================
// datapath widths
// ==============================

`define FETCH_BUS_WIDTH 64 // pc and byte address width

`define FETCH_INSTR_WIDTH 32 // one fetched word, no compressed forms

`define FETCH_INSTR_BYTES (`FETCH_INSTR_WIDTH / 8) // byte enables per word

// ==============================
// storage sizes
// ==============================

`define FETCH_IMEM_ADDR_BITS 10 // word address into instr memory

`define FETCH_IMEM_DEPTH (1 << `FETCH_IMEM_ADDR_BITS) // words held

`define FETCH_BHT_INDEX_BITS 6 // taken from pc word bits

`define FETCH_BHT_DEPTH (1 << `FETCH_BHT_INDEX_BITS) // counters in table

`endif

// ==== riscv_isa_pkg.sv ====
package riscv_isa_pkg;

    // ==============================
    // opcodes
    // ==============================
    typedef logic [6:0] opcode_t; // bits [6:0] in every format

    localparam opcode_t OP_BRANCH = 7'b1100011; // beq/bne/blt/bge/bltu/bgeu
    localparam opcode_t OP_JAL    = 7'b1101111; // pc-relative jump and link

    // ==============================
    // instruction formats
    // ==============================
    typedef struct packed {
        logic       imm_12;    // sign bit of offset
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;    // compare kind, not needed for prediction
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_type_t;

    typedef struct packed {
        logic       imm_20;    // sign bit of offset
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;        // link register
        opcode_t    opcode;
    } j_type_t;

    // same 32 bits seen as branch or as jump
    typedef union packed {
        b_type_t b_fmt;
        j_type_t j_fmt;
    } instr_word_u;

    typedef logic signed [12:0] b_off_t; // +-4 KiB, bit 0 always zero
    typedef logic signed [20:0] j_off_t; // +-1 MiB, bit 0 always zero

    // reassemble the scattered immediate of a conditional branch
    function automatic b_off_t b_offset(input instr_word_u w);
        b_offset = {w.b_fmt.imm_12, w.b_fmt.imm_11, w.b_fmt.imm_10_5,
                    w.b_fmt.imm_4_1, 1'b0};
    endfunction

    // reassemble the jal immediate
    function automatic j_off_t j_offset(input instr_word_u w);
        j_offset = {w.j_fmt.imm_20, w.j_fmt.imm_19_12, w.j_fmt.imm_11,
                    w.j_fmt.imm_10_1, 1'b0};
    endfunction

endpackage

// ==== fetch_pkg.sv ====
`include "fetch_params.svh"

package fetch_pkg;

    // ==============================
    // basic types
    // ==============================
    typedef logic [`FETCH_BUS_WIDTH-1:0]      pc_t;        // byte address
    typedef logic [`FETCH_INSTR_WIDTH-1:0]    instr_t;
    typedef logic [`FETCH_IMEM_ADDR_BITS-1:0] imem_addr_t; // word address
    typedef logic [`FETCH_BHT_INDEX_BITS-1:0] bht_index_t;
    typedef logic [1:0]                       bht_counter_t;

    localparam bht_counter_t BHT_MIN  = 2'd0; // strongly not taken
    localparam bht_counter_t BHT_INIT = 2'd1; // weakly not taken
    localparam bht_counter_t BHT_MAX  = 2'd3; // strongly taken

    // ==============================
    // loader port
    // ==============================
    typedef struct packed {
        logic                           en;   // access this cycle
        logic [`FETCH_INSTR_BYTES-1:0]  we;   // per byte, zero means read only
        imem_addr_t                     addr;
        instr_t                         din;
    } imem_load_t;

    // ==============================
    // fetch result and branch record
    // ==============================
    typedef struct packed {
        pc_t    pc;    // address of instr
        instr_t instr; // valid in the same cycle
    } fetch_out_t;

    // branch fetched last cycle, now sitting in decode
    typedef struct packed {
        logic         valid;
        logic         predicted_taken;
        bht_index_t   bht_index; // entry to train
        bht_counter_t counter;   // value used for the prediction
    } pending_branch_t;

endpackage

// ==== instr_mem.sv ====
`timescale 1ns/100ps
`include "fetch_params.svh"

module instr_mem (
    input  logic                  clk,
    input  fetch_pkg::imem_addr_t fetch_addr,  // word index from pc
    output fetch_pkg::instr_t     fetch_instr, // async read
    input  fetch_pkg::imem_load_t load,        // loader request
    output fetch_pkg::instr_t     load_dout    // one cycle after load.en
);
    import fetch_pkg::*;

    // ==============================
    // storage
    // ==============================
    instr_t mem [`FETCH_IMEM_DEPTH] = '{default: '0}; // program starts as zeros
    instr_t merged;                                  // old word with new bytes laid in

    // ==============================
    // fetch port
    // ==============================
    assign fetch_instr = mem[fetch_addr]; // pc and instr line up in one cycle

    // ==============================
    // loader port
    // ==============================
    always_comb begin
        merged = mem[load.addr];
        for (int b = 0; b < `FETCH_INSTR_BYTES; b++) begin
            if (load.we[b]) begin
                merged[8*b +: 8] = load.din[8*b +: 8]; // byte lane b
            end
        end
    end

    // write-first, a read in the write cycle returns the merged word
    always_ff @(posedge clk) begin
        if (load.en) begin
            if (|load.we) begin
                mem[load.addr] <= merged; // visible to fetch next cycle
            end
            load_dout <= merged; // registered read back
        end
    end

endmodule

// ==== branch_predictor.sv ====
`timescale 1ns/100ps
`include "fetch_params.svh"

module branch_predictor (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,               // freeze record and table
    input  fetch_pkg::pc_t             if_pc,               // byte pc in fetch
    input  riscv_isa_pkg::instr_word_u if_instr,            // word at if_pc
    input  logic                       id_branch_taken,     // real outcome from decode
    input  fetch_pkg::pc_t             next_unpredicted_pc, // decode's correction or pc + 4
    output fetch_pkg::pc_t             next_predicted_pc,
    output logic                       prediction_failed,
    output logic                       consecutive_stall
);
    import fetch_pkg::*;
    import riscv_isa_pkg::*;

    // ==============================
    // state
    // ==============================
    bht_counter_t    bht [`FETCH_BHT_DEPTH]; // 2-bit saturating counters
    pending_branch_t pending;                // branch now in decode

    // ==============================
    // fetch side decode
    // ==============================
    bht_index_t   if_index;
    bht_counter_t if_counter;
    logic         if_is_branch;
    logic         if_is_jal;
    logic         if_predict_taken;
    pc_t          b_target;
    pc_t          j_target;
    logic         resolving;

    // one step toward the real outcome, held at both ends
    function automatic bht_counter_t counter_step(input bht_counter_t cnt,
                                                  input logic taken);
        bht_counter_t nxt;
        nxt = cnt;
        if (taken && cnt != BHT_MAX) begin
            nxt = cnt + 2'd1;
        end else if (!taken && cnt != BHT_MIN) begin
            nxt = cnt - 2'd1;
        end
        return nxt;
    endfunction

    assign if_index         = if_pc[`FETCH_BHT_INDEX_BITS+1:2]; // word bits, skip byte offset
    assign if_counter       = bht[if_index];
    assign if_predict_taken = if_counter[1];                    // upper bit = taken

    // the same word read as a branch and as a jump
    assign if_is_branch = (if_instr.b_fmt.opcode == OP_BRANCH);
    assign if_is_jal    = (if_instr.j_fmt.opcode == OP_JAL);

    assign b_target = if_pc + pc_t'(b_offset(if_instr)); // sign extended offset
    assign j_target = if_pc + pc_t'(j_offset(if_instr));

    // ==============================
    // resolution of the pending branch
    // ==============================
    assign resolving         = pending.valid && !stall; // decode holds its outcome while stalled
    assign prediction_failed = resolving && (id_branch_taken != pending.predicted_taken);

    // back to back branches, hold pc so the next lookup sees the trained counter
    assign consecutive_stall = resolving && if_is_branch && !prediction_failed;

    // ==============================
    // next fetch address
    // ==============================
    always_comb begin
        if (prediction_failed) begin
            next_predicted_pc = next_unpredicted_pc; // redirect from decode
        end else if (if_is_jal) begin
            next_predicted_pc = j_target;            // jumps always taken
        end else if (if_is_branch && if_predict_taken) begin
            next_predicted_pc = b_target;
        end else begin
            next_predicted_pc = if_pc + 'd4;         // fall through
        end
    end

    // ==============================
    // table training and record
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            pending.valid <= 1'b0;
            for (int i = 0; i < `FETCH_BHT_DEPTH; i++) begin
                bht[i] <= BHT_INIT; // weakly not taken
            end
        end else if (!stall) begin
            if (pending.valid) begin
                bht[pending.bht_index] <= counter_step(pending.counter, id_branch_taken);
            end
            // word in fetch is dropped on a failure and refetched on a hold
            if (prediction_failed || consecutive_stall) begin
                pending.valid <= 1'b0;
            end else begin
                pending.valid <= if_is_branch;
            end
            pending.predicted_taken <= if_predict_taken;
            pending.bht_index       <= if_index;
            pending.counter         <= if_counter;
        end
    end

endmodule

// ==== if_stage.sv ====
`timescale 1ns/100ps
`include "fetch_params.svh"

module if_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,           // hold pc, record and counters
    input  logic                  imm_pc,          // take next_imm_pc instead of pc + 4
    input  logic                  id_branch_taken, // outcome of branch in decode
    input  fetch_pkg::pc_t        next_imm_pc,     // byte address from decode
    input  fetch_pkg::imem_load_t load,
    output fetch_pkg::fetch_out_t fetch,
    output logic                  branch_prediction_failed, // decode drops its instr
    output fetch_pkg::instr_t     load_dout
);
    import fetch_pkg::*;
    import riscv_isa_pkg::*;

    // ==============================
    // program counter
    // ==============================
    pc_t         pc_word;             // word index, byte pc is this << 2
    pc_t         pc;
    pc_t         next_unpredicted_pc;
    pc_t         next_predicted_pc;
    instr_word_u instr;
    logic        prediction_failed;
    logic        consecutive_stall;

    assign pc                  = pc_word << 2;
    assign next_unpredicted_pc = imm_pc ? next_imm_pc : pc + 'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_word <= '0;
        end else if (!stall && !consecutive_stall) begin
            pc_word <= next_predicted_pc >> 2; // drop byte offset
        end
    end

    // ==============================
    // prediction
    // ==============================
    branch_predictor u_branch_predictor (
        .clk                 (clk),
        .rst                 (rst),
        .stall               (stall),
        .if_pc               (pc),
        .if_instr            (instr),
        .id_branch_taken     (id_branch_taken),
        .next_unpredicted_pc (next_unpredicted_pc),
        .next_predicted_pc   (next_predicted_pc),
        .prediction_failed   (prediction_failed),
        .consecutive_stall   (consecutive_stall)
    );

    // a hold also invalidates what decode sees this cycle
    assign branch_prediction_failed = prediction_failed | consecutive_stall;

    // ==============================
    // instruction memory
    // ==============================
    instr_mem u_instr_mem (
        .clk         (clk),
        .fetch_addr  (pc_word[`FETCH_IMEM_ADDR_BITS-1:0]), // wraps past the top
        .fetch_instr (instr),
        .load        (load),
        .load_dout   (load_dout)
    );

    assign fetch.pc    = pc;
    assign fetch.instr = instr; // same cycle as pc

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_top (
    input  logic                  clk,
    input  logic                  rst,

    // decode side
    input  logic                  stall,           // back-pressure from decode
    input  logic                  imm_pc,          // correction valid this cycle
    input  logic                  id_branch_taken, // outcome of last fetched branch
    input  fetch_pkg::pc_t        next_imm_pc,     // corrected byte address

    // loader side
    input  fetch_pkg::imem_load_t load,

    // results
    output fetch_pkg::fetch_out_t fetch,                    // pc and word, same cycle
    output logic                  branch_prediction_failed, // discard current instr
    output fetch_pkg::instr_t     load_dout                 // loader read data
);

    // ==============================
    // fetch stage
    // ==============================
    if_stage u_if_stage (
        .clk                      (clk),
        .rst                      (rst),
        .stall                    (stall),
        .imm_pc                   (imm_pc),
        .id_branch_taken          (id_branch_taken),
        .next_imm_pc              (next_imm_pc),
        .load                     (load),
        .fetch                    (fetch),
        .branch_prediction_failed (branch_prediction_failed),
        .load_dout                (load_dout)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40, // one full clock cycle
    parameter int RESET_CYCLES = 5   // rising edges with rst high
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk; // 50 percent duty
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0; // released on an edge, like any other input
    end

endmodule

// ==== fetch_tb.sv ====
`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_tb;
    import fetch_pkg::*;

    // ==============================
    // constants and table layout
    // ==============================
    localparam int         CLK_PERIOD_NS = 40;
    localparam int         MAX_ROWS      = 256;
    localparam logic [6:0] OPC_IMM       = 7'b0010011; // addi family, plain filler
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [1:0] KIND_PLAIN    = 2'd0;
    localparam logic [1:0] KIND_BRANCH   = 2'd1;
    localparam logic [1:0] KIND_JAL      = 2'd2;

    typedef enum logic [1:0] {ROW_LOAD, ROW_READ, ROW_STEP, ROW_STALL} row_op_t;

    typedef struct packed {
        row_op_t    op;
        logic [3:0] be;    // byte enables of a load
        imem_addr_t addr;  // word address for load and read back
        instr_t     data;  // load data, or expected word on read back
        logic       taken; // decode outcome of the branch in decode
    } row_t;

    // ==============================
    // DUT wiring
    // ==============================
    logic       clk;
    logic       rst;
    logic       stall;
    logic       imm_pc;
    logic       id_branch_taken;
    pc_t        next_imm_pc;
    imem_load_t load;
    fetch_out_t fetch;
    logic       branch_prediction_failed;
    instr_t     load_dout;

    // stimulus table and program image
    row_t        rows [MAX_ROWS];
    int          n_rows      = 0;
    logic        table_ready = 1'b0;
    logic [31:0] rng         = 32'h82488390;     // xorshift state
    instr_t      img    [`FETCH_IMEM_DEPTH];     // what the memory should hold
    logic [1:0]  kind   [`FETCH_IMEM_DEPTH];     // plain, branch or jal per word
    pc_t         off_of [`FETCH_IMEM_DEPTH];     // byte offset of branch or jal

    // reference model of pc, counters and pending branch
    pc_t         m_pc;
    logic [1:0]  ctr [`FETCH_BHT_DEPTH];
    logic        p_valid;
    logic        p_pred;
    bht_index_t  p_idx;
    logic [1:0]  p_ctr;   // counter value when fetched
    pc_t         p_pc;
    pc_t         p_target;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(5)) u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    fetch_top uut (
        .clk                      (clk),
        .rst                      (rst),
        .stall                    (stall),
        .imm_pc                   (imm_pc),
        .id_branch_taken          (id_branch_taken),
        .next_imm_pc              (next_imm_pc),
        .load                     (load),
        .fetch                    (fetch),
        .branch_prediction_failed (branch_prediction_failed),
        .load_dout                (load_dout)
    );

    // ==============================
    // helpers
    // ==============================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // saturating two-bit counter, one step toward the outcome
    function automatic logic [1:0] train_counter(input logic [1:0] c, input logic taken);
        if (taken) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic compare_fetch(input logic exp_failed);
        check_value("fetch.pc", fetch.pc, m_pc);
        check_value("fetch.instr", 64'(fetch.instr), 64'(img[m_pc[`FETCH_IMEM_ADDR_BITS+1:2]]));
        check_value("branch_prediction_failed", 64'(branch_prediction_failed), 64'(exp_failed));
    endtask

    task automatic add_row(input row_op_t op, input logic [3:0] be, input imem_addr_t addr,
                           input instr_t data, input logic taken);
        row_t r;
        r = '{op: op, be: be, addr: addr, data: data, taken: taken};
        if (op == ROW_LOAD) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    img[addr][8*b +: 8] = data[8*b +: 8]; // merge one byte lane
                end
            end
        end else if (op == ROW_READ) begin
            r.data = img[addr]; // expected read back
        end
        rows[n_rows] = r;
        n_rows++;
    endtask

    // full write, then a partial write over the middle bytes, then read back
    task automatic filler_word(input int a);
        logic [31:0] r;
        r = next_random();
        add_row(ROW_LOAD, 4'b1111, imem_addr_t'(a), {r[31:7], OPC_IMM}, 1'b0);
        add_row(ROW_LOAD, 4'b0110, imem_addr_t'(a), next_random(), 1'b0); // opcode byte kept
        add_row(ROW_READ, 4'b0000, imem_addr_t'(a), '0, 1'b0);
    endtask

    task automatic jal_word(input int a, input int target);
        pc_t off;
        off       = pc_t'(4 * (target - a));
        kind[a]   = KIND_JAL;
        off_of[a] = off;
        add_row(ROW_LOAD, 4'b1111, imem_addr_t'(a),
                {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL}, 1'b0); // rd = ra
        add_row(ROW_READ, 4'b0000, imem_addr_t'(a), '0, 1'b0);
    endtask

    task automatic branch_word(input int a, input int off_bytes);
        pc_t         off;
        logic [31:0] r;
        off       = pc_t'(off_bytes);
        r         = next_random(); // rs2, rs1 and funct3 at random
        kind[a]   = KIND_BRANCH;
        off_of[a] = off;
        add_row(ROW_LOAD, 4'b1111, imem_addr_t'(a),
                {off[12], off[10:5], r[24:12], off[4:1], off[11], OPC_BRANCH}, 1'b0);
        add_row(ROW_READ, 4'b0000, imem_addr_t'(a), '0, 1'b0);
    endtask

    // ==============================
    // program and stimulus table
    // ==============================
    task automatic build_table();
        logic [31:0] r;
        logic        taken;
        for (int a = 0; a < 8; a++) begin
            filler_word(a);                          // straight line code
        end
        jal_word(8, 12);
        branch_word(12, 8);                          // back to back pair, both reach word 14
        branch_word(13, 4);
        filler_word(14);
        jal_word(15, 16);
        filler_word(16);                             // loop head
        r = next_random();
        branch_word(17, 4 * (2 + int'(r[2:0])));     // random target in words 19..26
        for (int a = 18; a < 27; a++) begin
            jal_word(a, 16);                         // every way out goes back to 16
        end
        for (int s = 0; s < 14; s++) begin
            add_row(ROW_STEP, '0, '0, '0, 1'b0);     // pair resolves not taken
        end
        for (int s = 0; s < 120; s++) begin
            r     = next_random();
            taken = (s < 60) ? (r[1:0] != 2'b00) : (r[1:0] == 2'b00); // push up, then down
            add_row(ROW_STEP, '0, '0, '0, taken);
            if (s % 6 == 5) begin
                add_row(ROW_STALL, '0, '0, '0, r[2]); // outcome must be ignored
            end
        end
    endtask

    // ==============================
    // row handlers
    // ==============================
    task automatic load_row(input row_t r);
        @(posedge clk);
        stall  <= 1'b1;                              // pc parked while loading
        imm_pc <= 1'b0;
        load   <= '{en: 1'b1, we: r.be, addr: r.addr, din: r.data};
        @(negedge clk);
        check_value("fetch.pc", fetch.pc, m_pc);
    endtask

    task automatic read_back(input row_t r);
        @(posedge clk);
        stall <= 1'b1;
        load  <= '{en: 1'b1, we: 4'b0000, addr: r.addr, din: '0};
        @(posedge clk);
        load  <= '0;
        @(negedge clk);                              // registered, one cycle after en
        check_value("load_dout", 64'(load_dout), 64'(r.data));
    endtask

    task automatic stall_cycle(input row_t r);
        @(posedge clk);
        stall           <= 1'b1;
        imm_pc          <= 1'b0;
        id_branch_taken <= r.taken;
        load            <= '0;
        @(negedge clk);
        compare_fetch(1'b0);                         // nothing resolves under stall
    endtask

    task automatic fetch_step(input row_t r);
        logic       fail;
        logic       consec;
        logic [1:0] cur;
        bht_index_t idx;
        imem_addr_t word;
        pc_t        corr;
        pc_t        next_pc;
        fail = p_valid && (r.taken != p_pred);
        corr = r.taken ? p_target : p_pc + 64'd4;    // real next address of the branch
        @(posedge clk);
        stall           <= 1'b0;
        load            <= '0;
        id_branch_taken <= r.taken;
        imm_pc          <= fail;
        next_imm_pc     <= fail ? corr : {next_random(), next_random()}; // junk if unused
        @(negedge clk);
        word   = m_pc[`FETCH_IMEM_ADDR_BITS+1:2];
        idx    = m_pc[`FETCH_BHT_INDEX_BITS+1:2];
        consec = p_valid && !fail && (kind[word] == KIND_BRANCH);
        compare_fetch(fail | consec);
        cur = ctr[idx];                              // lookup before this edge trains
        if (p_valid) begin
            ctr[p_idx] = train_counter(p_ctr, r.taken);
        end
        if (fail) begin
            next_pc = corr;
        end else if (consec) begin
            next_pc = m_pc;                          // refetch with trained counter
        end else if (kind[word] == KIND_JAL || (kind[word] == KIND_BRANCH && cur[1])) begin
            next_pc = m_pc + off_of[word];
        end else begin
            next_pc = m_pc + 64'd4;
        end
        p_valid  = !fail && !consec && (kind[word] == KIND_BRANCH);
        p_pred   = cur[1];
        p_idx    = idx;
        p_ctr    = cur;
        p_pc     = m_pc;
        p_target = m_pc + off_of[word];
        m_pc     = next_pc;
    endtask

    // ==============================
    // main sequence and watchdog
    // ==============================
    initial begin
        $timeformat(-9, 1, " ns", 0);
        stall           = 1'b0;                      // only rst keeps pc at 0 here
        imm_pc          = 1'b0;
        id_branch_taken = 1'b0;
        next_imm_pc     = '0;
        load            = '0;
        for (int i = 0; i < `FETCH_IMEM_DEPTH; i++) begin
            img[i]    = '0;
            kind[i]   = KIND_PLAIN;
            off_of[i] = '0;
        end
        for (int i = 0; i < `FETCH_BHT_DEPTH; i++) begin
            ctr[i] = 2'd1;                           // weakly not taken after reset
        end
        m_pc     = '0;
        p_valid  = 1'b0;
        p_pred   = 1'b0;
        p_idx    = '0;
        p_ctr    = '0;
        p_pc     = '0;
        p_target = '0;
        build_table();
        table_ready = 1'b1;
        @(posedge clk);
        while (rst) begin
            @(negedge clk);
        end
        check_value("fetch.pc", fetch.pc, '0);
        check_value("branch_prediction_failed", 64'(branch_prediction_failed), 64'd0);
        m_pc = m_pc + 64'd4;                         // empty memory falls through on the next edge
        for (int i = 0; i < n_rows; i++) begin
            case (rows[i].op)
                ROW_LOAD:  load_row(rows[i]);
                ROW_READ:  read_back(rows[i]);
                ROW_STEP:  fetch_step(rows[i]);
                default:   stall_cycle(rows[i]);
            endcase
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // two cycles per row covers read back, plus reset and slack
    initial begin
        wait (table_ready);
        #((n_rows * 2 + 20) * CLK_PERIOD_NS);
        $display("timeout: the stimulus table did not finish in the expected time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== compile.f ====
+incdir+.
riscv_isa_pkg.sv
fetch_pkg.sv
instr_mem.sv
branch_predictor.sv
if_stage.sv
fetch_top.sv
tb_clock_gen.sv
fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fetch testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fetch_tb -f compile.f -o fetch_sim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0
